// ==== core_pkg.sv ====
/*
 * Shared widths, scalar types, ALU and sequencing enums,
 * decoded-control and retirement record structs
 */

package core_pkg;

  parameter int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [31:0]     instr_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [63:0]     order_t;

  //////////////////////////////////////////////////////////////////////
  // Enums
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    ST_FETCH,
    ST_EXECUTE,
    ST_MEMORY,
    ST_WRITEBACK
  } core_state_e;

  //////////////////////////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////////////////////////

  // Decoder output for one instruction
  typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    alu_op_e   alu_op;
    logic      imm_sel;
    logic      reg_we;
    logic      load;
    logic      store;
    logic      branch;
    logic      branch_ne;
    logic      jal;
    logic      trap;
  } ctrl_t;

  // Trace record with all-or-nothing masks for word accesses
  typedef struct packed {
    instr_t    insn;
    word_t     pc_rdata;
    word_t     pc_wdata;
    reg_addr_t rd_addr;
    word_t     rd_wdata;
    word_t     mem_addr;
    logic [3:0] mem_rmask;
    logic [3:0] mem_wmask;
    word_t     mem_rdata;
    word_t     mem_wdata;
    logic      trap;
  } retire_t;

endpackage

// ==== core_alu.sv ====
/*
 * ALU for the supported operations and branch equality compare
 */

`timescale 1ns/1ps

module core_alu (
  input  core_pkg::alu_op_e op_i,
  input  core_pkg::word_t   a_i,
  input  core_pkg::word_t   b_i,
  output core_pkg::word_t   result_o,
  output logic              equal_o
);

  import core_pkg::*;

  logic less_signed;

  assign less_signed = $signed(a_i) < $signed(b_i);

  always_comb begin
    case (op_i)
      ALU_ADD: begin
        result_o = a_i + b_i;
      end
      ALU_SUB: begin
        result_o = a_i - b_i;
      end
      ALU_AND: begin
        result_o = a_i & b_i;
      end
      ALU_OR: begin
        result_o = a_i | b_i;
      end
      ALU_XOR: begin
        result_o = a_i ^ b_i;
      end
      ALU_SLT: begin
        result_o = {{(XLEN-1){1'b0}}, less_signed};
      end
      ALU_PASS_B: begin
        result_o = b_i;
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

  // Used by BEQ and BNE
  assign equal_o = (a_i == b_i);

endmodule

// ==== core_decoder.sv ====
/*
 * RV32I subset decoder with I, S, B, U and J immediates
 */

`timescale 1ns/1ps

module core_decoder (
  input  core_pkg::instr_t instr_i,
  output core_pkg::ctrl_t  ctrl_o
);

  import core_pkg::*;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  logic       illegal;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    ctrl_o        = '0;
    ctrl_o.rs1    = instr_i[19:15];
    ctrl_o.rs2    = instr_i[24:20];
    ctrl_o.rd     = instr_i[11:7];
    ctrl_o.alu_op = ALU_ADD;
    illegal       = 1'b0;

    case (opcode)
      OPC_OP: begin
        ctrl_o.reg_we = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: ctrl_o.alu_op = ALU_ADD;
          10'b0100000_000: ctrl_o.alu_op = ALU_SUB;
          10'b0000000_010: ctrl_o.alu_op = ALU_SLT;
          10'b0000000_100: ctrl_o.alu_op = ALU_XOR;
          10'b0000000_110: ctrl_o.alu_op = ALU_OR;
          10'b0000000_111: ctrl_o.alu_op = ALU_AND;
          default:         illegal = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        ctrl_o.reg_we  = 1'b1;
        ctrl_o.imm_sel = 1'b1;
        ctrl_o.imm     = imm_i;
        case (funct3)
          3'b000:  ctrl_o.alu_op = ALU_ADD;
          3'b100:  ctrl_o.alu_op = ALU_XOR;
          3'b110:  ctrl_o.alu_op = ALU_OR;
          3'b111:  ctrl_o.alu_op = ALU_AND;
          default: illegal = 1'b1;
        endcase
      end
      OPC_LUI: begin
        ctrl_o.reg_we  = 1'b1;
        ctrl_o.imm_sel = 1'b1;
        ctrl_o.imm     = imm_u;
        ctrl_o.alu_op  = ALU_PASS_B;
      end
      OPC_LOAD: begin
        ctrl_o.reg_we  = 1'b1;
        ctrl_o.load    = 1'b1;
        ctrl_o.imm_sel = 1'b1;
        ctrl_o.imm     = imm_i;
        illegal        = (funct3 != 3'b010);
      end
      OPC_STORE: begin
        ctrl_o.store   = 1'b1;
        ctrl_o.imm_sel = 1'b1;
        ctrl_o.imm     = imm_s;
        illegal        = (funct3 != 3'b010);
      end
      OPC_BRANCH: begin
        ctrl_o.branch    = 1'b1;
        ctrl_o.branch_ne = funct3[0];
        ctrl_o.imm       = imm_b;
        illegal          = (funct3[2:1] != 2'b00);
      end
      OPC_JAL: begin
        ctrl_o.reg_we = 1'b1;
        ctrl_o.jal    = 1'b1;
        ctrl_o.imm    = imm_j;
      end
      default: illegal = 1'b1;
    endcase

    // Unsupported encodings retire as traps with nothing enabled
    if (illegal) begin
      ctrl_o.reg_we    = 1'b0;
      ctrl_o.load      = 1'b0;
      ctrl_o.store     = 1'b0;
      ctrl_o.branch    = 1'b0;
      ctrl_o.branch_ne = 1'b0;
      ctrl_o.jal       = 1'b0;
      ctrl_o.trap      = 1'b1;
    end
  end

endmodule

// ==== core_regfile.sv ====
/*
 * 32-entry register file, two read ports, one write port, x0 fixed
 */

`timescale 1ns/1ps

module core_regfile (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  core_pkg::reg_addr_t rs1_i,
  input  core_pkg::reg_addr_t rs2_i,
  input  core_pkg::reg_addr_t rd_i,
  input  logic                we_i,
  input  core_pkg::word_t     wdata_i,
  output core_pkg::word_t     rdata1_o,
  output core_pkg::word_t     rdata2_o
);

  import core_pkg::*;

  word_t regs_q [1:31];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (rd_i != '0)) begin
      regs_q[rd_i] <= wdata_i;
    end
  end

  assign rdata1_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
  assign rdata2_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

// ==== core_pc_unit.sv ====
/*
 * Program counter with sequential, branch and jump next-pc selection
 */

`timescale 1ns/1ps

module core_pc_unit #(
  parameter core_pkg::word_t BOOT_ADDR = '0
) (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            update_i,
  input  core_pkg::ctrl_t ctrl_i,
  input  logic            rs_equal_i,
  output core_pkg::word_t pc_o,
  output core_pkg::word_t next_pc_o
);

  import core_pkg::*;

  word_t pc_q;
  logic  take_target;

  // BNE flips the sense of the equality result
  assign take_target = ctrl_i.jal | (ctrl_i.branch & (rs_equal_i ^ ctrl_i.branch_ne));

  assign next_pc_o = take_target ? pc_q + ctrl_i.imm : pc_q + XLEN'(4);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= BOOT_ADDR;
    end else if (update_i) begin
      pc_q <= next_pc_o;
    end
  end

  assign pc_o = pc_q;

endmodule

// ==== core_lsu.sv ====
/*
 * Data port request register, held until the memory response
 */

`timescale 1ns/1ps

module core_lsu (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            start_i,
  input  logic            we_i,
  input  core_pkg::word_t addr_i,
  input  core_pkg::word_t wdata_i,
  input  logic            data_rvalid_i,
  input  core_pkg::word_t data_rdata_i,
  output logic            data_req_o,
  output logic            data_we_o,
  output core_pkg::word_t data_addr_o,
  output core_pkg::word_t data_wdata_o,
  output logic            done_o,
  output core_pkg::word_t rdata_o
);

  import core_pkg::*;

  logic  req_q;
  logic  we_q;
  word_t addr_q;
  word_t wdata_q;
  word_t rdata_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_q <= 1'b0;
    end else if (start_i) begin
      req_q <= 1'b1;
    end else if (done_o) begin
      req_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
    if (done_o) begin
      rdata_q <= data_rdata_i;
    end
  end

  assign done_o = req_q & data_rvalid_i;

  // Live response in the done cycle, captured word afterwards
  assign rdata_o = done_o ? data_rdata_i : rdata_q;

  assign data_req_o   = req_q;
  assign data_we_o    = we_q;
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;

endmodule

// ==== core_retire.sv ====
/*
 * Retirement record register and instruction order counter
 */

`timescale 1ns/1ps

module core_retire (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              retire_i,
  input  core_pkg::retire_t record_i,
  output logic              valid_o,
  output core_pkg::order_t  order_o,
  output core_pkg::retire_t record_o
);

  import core_pkg::*;

  logic    valid_q;
  order_t  order_q;
  retire_t record_q;

  // Order moves on once the current retirement has been presented
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      order_q <= '0;
    end else begin
      valid_q <= retire_i;
      if (valid_q) begin
        order_q <= order_q + order_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (retire_i) begin
      record_q <= record_i;
    end
  end

  assign valid_o  = valid_q;
  assign order_o  = order_q;
  assign record_o = record_q;

endmodule

// ==== core_ctrl_fsm.sv ====
/*
 * Instruction sequencing FSM through fetch, execute, memory and writeback
 */

`timescale 1ns/1ps

module core_ctrl_fsm (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           instr_rvalid_i,
  input  core_pkg::ctrl_t ctrl_i,
  input  logic           lsu_done_i,
  output logic           instr_req_o,
  output logic           instr_latch_o,
  output logic           lsu_start_o,
  output logic           reg_we_o,
  output logic           pc_update_o,
  output logic           retire_o
);

  import core_pkg::*;

  core_state_e state_q;
  core_state_e state_d;
  logic        req_q;
  logic        mem_access;

  assign mem_access = ctrl_i.load | ctrl_i.store;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_FETCH: begin
        if (instr_latch_o) begin
          state_d = ST_EXECUTE;
        end
      end
      ST_EXECUTE: begin
        state_d = mem_access ? ST_MEMORY : ST_WRITEBACK;
      end
      ST_MEMORY: begin
        if (lsu_done_i) begin
          state_d = ST_WRITEBACK;
        end
      end
      default: begin
        state_d = ST_FETCH;
      end
    endcase
  end

  // Fetch request rises one cycle after reset and after each writeback
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_FETCH;
      req_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      req_q   <= (state_d == ST_FETCH);
    end
  end

  assign instr_req_o   = req_q;
  assign instr_latch_o = (state_q == ST_FETCH) & req_q & instr_rvalid_i;
  assign lsu_start_o   = (state_q == ST_EXECUTE) & mem_access;

  // Record is captured on entry to writeback so valid lines up with it
  assign retire_o = ((state_q == ST_EXECUTE) & ~mem_access) |
                    ((state_q == ST_MEMORY) & lsu_done_i);

  assign reg_we_o    = (state_q == ST_WRITEBACK) & ctrl_i.reg_we & ~ctrl_i.trap;
  assign pc_update_o = (state_q == ST_WRITEBACK);

endmodule

// ==== core_top.sv ====
/*
 * Single-issue RV32I subset core with sequencing FSM, datapath and trace port
 */

`timescale 1ns/1ps

module core_top #(
  parameter core_pkg::word_t BOOT_ADDR = '0
) (
  input  logic              clk_i,
  input  logic              arst_n_i,

  // Instruction port
  output logic              instr_req_o,
  output core_pkg::word_t   instr_addr_o,
  input  logic              instr_rvalid_i,
  input  core_pkg::instr_t  instr_rdata_i,

  // Data port
  output logic              data_req_o,
  output logic              data_we_o,
  output core_pkg::word_t   data_addr_o,
  output core_pkg::word_t   data_wdata_o,
  input  logic              data_rvalid_i,
  input  core_pkg::word_t   data_rdata_i,

  // Retirement trace
  output logic              retire_valid_o,
  output core_pkg::order_t  retire_order_o,
  output core_pkg::retire_t retire_o
);

  import core_pkg::*;

  instr_t  instr_q;
  ctrl_t   ctrl;
  logic    instr_latch;
  logic    lsu_start;
  logic    lsu_done;
  logic    reg_we;
  logic    pc_update;
  logic    retire;
  word_t   pc;
  word_t   next_pc;
  word_t   pc_plus4;
  word_t   rs1_data;
  word_t   rs2_data;
  word_t   alu_b;
  word_t   alu_result;
  logic    rs_equal;
  word_t   load_data;
  word_t   wb_data;
  retire_t record;

  always_ff @(posedge clk_i) begin
    if (instr_latch) begin
      instr_q <= instr_rdata_i;
    end
  end

  assign instr_addr_o = pc;
  assign pc_plus4     = pc + XLEN'(4);
  assign alu_b        = ctrl.imm_sel ? ctrl.imm : rs2_data;

  // Writeback source
  assign wb_data = ctrl.jal  ? pc_plus4  :
                   ctrl.load ? load_data : alu_result;

  //////////////////////////////////////////////////////////////////////
  // Sequencing and datapath
  //////////////////////////////////////////////////////////////////////

  core_ctrl_fsm i_ctrl_fsm (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .ctrl_i         ( ctrl           ),
    .lsu_done_i     ( lsu_done       ),
    .instr_req_o    ( instr_req_o    ),
    .instr_latch_o  ( instr_latch    ),
    .lsu_start_o    ( lsu_start      ),
    .reg_we_o       ( reg_we         ),
    .pc_update_o    ( pc_update      ),
    .retire_o       ( retire         )
  );

  core_pc_unit #(
    .BOOT_ADDR ( BOOT_ADDR )
  ) i_pc_unit (
    .clk_i      ( clk_i     ),
    .arst_n_i   ( arst_n_i  ),
    .update_i   ( pc_update ),
    .ctrl_i     ( ctrl      ),
    .rs_equal_i ( rs_equal  ),
    .pc_o       ( pc        ),
    .next_pc_o  ( next_pc   )
  );

  core_decoder i_decoder (
    .instr_i ( instr_q ),
    .ctrl_o  ( ctrl    )
  );

  core_alu i_alu (
    .op_i     ( ctrl.alu_op ),
    .a_i      ( rs1_data    ),
    .b_i      ( alu_b       ),
    .result_o ( alu_result  ),
    .equal_o  ( rs_equal    )
  );

  core_regfile i_regfile (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .rs1_i    ( ctrl.rs1 ),
    .rs2_i    ( ctrl.rs2 ),
    .rd_i     ( ctrl.rd  ),
    .we_i     ( reg_we   ),
    .wdata_i  ( wb_data  ),
    .rdata1_o ( rs1_data ),
    .rdata2_o ( rs2_data )
  );

  core_lsu i_lsu (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .start_i       ( lsu_start     ),
    .we_i          ( ctrl.store    ),
    .addr_i        ( alu_result    ),
    .wdata_i       ( rs2_data      ),
    .data_rvalid_i ( data_rvalid_i ),
    .data_rdata_i  ( data_rdata_i  ),
    .data_req_o    ( data_req_o    ),
    .data_we_o     ( data_we_o     ),
    .data_addr_o   ( data_addr_o   ),
    .data_wdata_o  ( data_wdata_o  ),
    .done_o        ( lsu_done      ),
    .rdata_o       ( load_data     )
  );

  //////////////////////////////////////////////////////////////////////
  // Retirement trace
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    record           = '0;
    record.insn      = instr_q;
    record.pc_rdata  = pc;
    record.pc_wdata  = next_pc;
    record.trap      = ctrl.trap;
    if (ctrl.reg_we && !ctrl.trap && (ctrl.rd != '0)) begin
      record.rd_addr  = ctrl.rd;
      record.rd_wdata = wb_data;
    end
    if (ctrl.load || ctrl.store) begin
      record.mem_addr = alu_result;
    end
    if (ctrl.load) begin
      record.mem_rmask = 4'hf;
      record.mem_rdata = load_data;
    end
    if (ctrl.store) begin
      record.mem_wmask = 4'hf;
      record.mem_wdata = rs2_data;
    end
  end

  core_retire i_retire (
    .clk_i    ( clk_i          ),
    .arst_n_i ( arst_n_i       ),
    .retire_i ( retire         ),
    .record_i ( record         ),
    .valid_o  ( retire_valid_o ),
    .order_o  ( retire_order_o ),
    .record_o ( retire_o       )
  );

endmodule

// ==== tb_core_model.svh ====
/*
 * ISA reference model state, step function and random program generator
 */

`ifndef TB_CORE_MODEL_SVH
`define TB_CORE_MODEL_SVH

localparam int          PROG_WORDS = 256;
localparam int          DATA_WORDS = 64;
localparam logic [31:0] DATA_BASE  = 32'h0000_0400;

logic [31:0] program_mem [PROG_WORDS];
logic [31:0] model_regs  [32];
logic [31:0] model_mem   [DATA_WORDS];
logic [31:0] model_pc;
logic [63:0] model_order;

function automatic int unsigned rand_below(int unsigned n);
  logic [31:0] r;
  r = $random(seed);
  return r % n;
endfunction

// Every word of the data region starts with a value tied to its address
function automatic logic [31:0] data_fill(logic [31:0] addr);
  return (addr * 32'h9e37_79b1) ^ {addr[15:0], ~addr[15:0]};
endfunction

function automatic int data_index(logic [31:0] addr);
  logic [31:0] offset;
  offset = addr - DATA_BASE;
  if (addr < DATA_BASE || offset >= 32'(DATA_WORDS * 4) || addr[1:0] != 2'b00) begin
    return -1;
  end
  return int'(offset[31:2]);
endfunction

//////////////////////////////////////////////////////////////////////
// Program generator
//////////////////////////////////////////////////////////////////////

function automatic logic [31:0] random_insn(int idx, int unsigned kind);
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [31:0] bits;
  logic [31:0] off;
  logic [11:0] maddr;
  logic [9:0]  fn;
  int          target;
  rd     = 5'(rand_below(8));
  rs1    = 5'(rand_below(8));
  rs2    = 5'(rand_below(8));
  bits   = $random(seed);
  // Mostly forward targets that wrap to the start near the end
  target = (idx + 1 + int'(rand_below(16))) % PROG_WORDS;
  off    = 32'((target - idx) * 4);
  maddr  = 12'(DATA_BASE + 32'(4 * rand_below(DATA_WORDS)));
  fn     = '0;
  case (kind)
    0, 1, 2, 3: begin
      case (rand_below(6))
        0:       fn = {7'b0000000, 3'b000};
        1:       fn = {7'b0100000, 3'b000};
        2:       fn = {7'b0000000, 3'b010};
        3:       fn = {7'b0000000, 3'b100};
        4:       fn = {7'b0000000, 3'b110};
        default: fn = {7'b0000000, 3'b111};
      endcase
      return {fn[9:3], rs2, rs1, fn[2:0], rd, 7'b0110011};
    end
    4, 5, 6: begin
      case (rand_below(4))
        0:       fn[2:0] = 3'b000;
        1:       fn[2:0] = 3'b100;
        2:       fn[2:0] = 3'b110;
        default: fn[2:0] = 3'b111;
      endcase
      return {bits[11:0], rs1, fn[2:0], rd, 7'b0010011};
    end
    7:      return {bits[31:12], rd, 7'b0110111};
    8, 9:   return {maddr, 5'd0, 3'b010, rd, 7'b0000011};
    10, 11: return {maddr[11:5], rs2, 5'd0, 3'b010, maddr[4:0], 7'b0100011};
    12, 13: begin
      return {off[12], off[10:5], rs2, rs1, 2'b00, kind == 13, off[4:1], off[11],
              7'b1100011};
    end
    14: return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    default: begin
      // Illegal ECALL, SLL and LB encodings
      case (rand_below(3))
        0:       return 32'h0000_0073;
        1:       return {7'b0000000, rs2, rs1, 3'b001, rd, 7'b0110011};
        default: return {bits[11:0], rs1, 3'b000, rd, 7'b0000011};
      endcase
    end
  endcase
endfunction

function automatic void build_program();
  for (int i = 0; i < PROG_WORDS; i++) begin
    // Last word always jumps, so the pc never leaves the program
    program_mem[i] = random_insn(i, (i == PROG_WORDS - 1) ? 14 : rand_below(16));
  end
endfunction

//////////////////////////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////////////////////////

function automatic void model_reset();
  for (int i = 0; i < 32; i++) begin
    model_regs[i] = '0;
  end
  for (int i = 0; i < DATA_WORDS; i++) begin
    model_mem[i] = data_fill(DATA_BASE + 32'(4 * i));
  end
  model_pc    = '0;
  model_order = '0;
endfunction

function automatic retire_t model_step();
  retire_t     r;
  logic [31:0] insn;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [31:0] res;
  logic [4:0]  rd;
  logic        wr;
  int          idx;
  insn  = program_mem[model_pc[9:2]];
  a     = model_regs[insn[19:15]];
  b     = model_regs[insn[24:20]];
  rd    = insn[11:7];
  imm_i = {{20{insn[31]}}, insn[31:20]};
  imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  res   = '0;
  wr    = 1'b1;
  r          = '0;
  r.insn     = insn;
  r.pc_rdata = model_pc;
  r.pc_wdata = model_pc + 32'd4;
  case (insn[6:0])
    7'b0110011: begin
      case ({insn[31:25], insn[14:12]})
        10'b0000000_000: res = a + b;
        10'b0100000_000: res = a - b;
        10'b0000000_010: res = {31'b0, $signed(a) < $signed(b)};
        10'b0000000_100: res = a ^ b;
        10'b0000000_110: res = a | b;
        10'b0000000_111: res = a & b;
        default:         r.trap = 1'b1;
      endcase
    end
    7'b0010011: begin
      case (insn[14:12])
        3'b000:  res = a + imm_i;
        3'b100:  res = a ^ imm_i;
        3'b110:  res = a | imm_i;
        3'b111:  res = a & imm_i;
        default: r.trap = 1'b1;
      endcase
    end
    7'b0110111: res = {insn[31:12], 12'b0};
    7'b0000011: begin
      if (insn[14:12] == 3'b010) begin
        r.mem_addr  = a + imm_i;
        r.mem_rmask = 4'hf;
        idx         = data_index(r.mem_addr);
        r.mem_rdata = (idx >= 0) ? model_mem[idx] : '0;
        res         = r.mem_rdata;
      end else begin
        r.trap = 1'b1;
      end
    end
    7'b0100011: begin
      wr = 1'b0;
      if (insn[14:12] == 3'b010) begin
        r.mem_addr  = a + imm_s;
        r.mem_wmask = 4'hf;
        r.mem_wdata = b;
        idx         = data_index(r.mem_addr);
        if (idx >= 0) begin
          model_mem[idx] = b;
        end
      end else begin
        r.trap = 1'b1;
      end
    end
    7'b1100011: begin
      wr = 1'b0;
      if (insn[14:13] == 2'b00) begin
        if ((a == b) != insn[12]) begin
          r.pc_wdata = model_pc + imm_b;
        end
      end else begin
        r.trap = 1'b1;
      end
    end
    7'b1101111: begin
      res        = model_pc + 32'd4;
      r.pc_wdata = model_pc + imm_j;
    end
    default: r.trap = 1'b1;
  endcase
  if (wr && !r.trap && rd != 5'd0) begin
    r.rd_addr      = rd;
    r.rd_wdata     = res;
    model_regs[rd] = res;
  end
  model_pc = r.pc_wdata;
  model_order++;
  return r;
endfunction

`endif

// ==== tb_core.sv ====
/*
 * Testbench for core_top with clock, reset, memory responders,
 * retirement checks against the ISA model and a watchdog
 */

`timescale 1ns/1ps

module tb_core;

  import core_pkg::*;

  localparam int     CLK_PERIOD  = 40;
  localparam int     INPUT_DELAY = 2;
  localparam int     NUM_INSNS   = 600;
  // Worst case is about 10 cycles per instruction
  localparam longint WATCHDOG_NS = longint'((NUM_INSNS * 12 + 8) * CLK_PERIOD);

  logic    clk;
  logic    arst_n;
  logic    instr_req;
  word_t   instr_addr;
  logic    instr_rvalid;
  instr_t  instr_rdata;
  logic    data_req;
  logic    data_we;
  word_t   data_addr;
  word_t   data_wdata;
  logic    data_rvalid;
  word_t   data_rdata;
  logic    retire_valid;
  order_t  retire_order;
  retire_t retire_rec;

  integer      seed;
  int          errors;
  int          checks;
  logic [31:0] data_mem [64];

  `include "tb_core_model.svh"

  core_top #(
    .BOOT_ADDR ( 32'h0000_0000 )
  ) dut (
    .clk_i          ( clk          ),
    .arst_n_i       ( arst_n       ),
    .instr_req_o    ( instr_req    ),
    .instr_addr_o   ( instr_addr   ),
    .instr_rvalid_i ( instr_rvalid ),
    .instr_rdata_i  ( instr_rdata  ),
    .data_req_o     ( data_req     ),
    .data_we_o      ( data_we      ),
    .data_addr_o    ( data_addr    ),
    .data_wdata_o   ( data_wdata   ),
    .data_rvalid_i  ( data_rvalid  ),
    .data_rdata_i   ( data_rdata   ),
    .retire_valid_o ( retire_valid ),
    .retire_order_o ( retire_order ),
    .retire_o       ( retire_rec   )
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_value(string field, logic [63:0] actual, logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch at %0d ns: %s is %h, expected %h", $time, field, actual, expected);
    end
  endtask

  task automatic compare_retire(retire_t exp);
    check_value("insn", 64'(retire_rec.insn), 64'(exp.insn));
    check_value("pc_rdata", 64'(retire_rec.pc_rdata), 64'(exp.pc_rdata));
    check_value("pc_wdata", 64'(retire_rec.pc_wdata), 64'(exp.pc_wdata));
    check_value("rd_addr", 64'(retire_rec.rd_addr), 64'(exp.rd_addr));
    check_value("rd_wdata", 64'(retire_rec.rd_wdata), 64'(exp.rd_wdata));
    check_value("mem_addr", 64'(retire_rec.mem_addr), 64'(exp.mem_addr));
    check_value("mem_rmask", 64'(retire_rec.mem_rmask), 64'(exp.mem_rmask));
    check_value("mem_wmask", 64'(retire_rec.mem_wmask), 64'(exp.mem_wmask));
    check_value("mem_rdata", 64'(retire_rec.mem_rdata), 64'(exp.mem_rdata));
    check_value("mem_wdata", 64'(retire_rec.mem_wdata), 64'(exp.mem_wdata));
    check_value("trap", 64'(retire_rec.trap), 64'(exp.trap));
  endtask

  function automatic instr_t fetch_word(word_t addr);
    if (addr >= 32'(PROG_WORDS * 4) || addr[1:0] != 2'b00) begin
      $display("Error at %0d ns: instruction fetch from %h is outside the program", $time, addr);
      errors++;
      return '0;
    end
    return program_mem[addr[9:2]];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Memory responders with 0 to 3 wait cycles
  //////////////////////////////////////////////////////////////////////

  initial begin : instr_responder
    int wait_cycles;
    forever begin
      @(posedge clk);
      #INPUT_DELAY;
      if (instr_req) begin
        wait_cycles = int'(rand_below(4));
        repeat (wait_cycles) begin
          @(posedge clk);
          #INPUT_DELAY;
        end
        instr_rvalid = 1'b1;
        instr_rdata  = fetch_word(instr_addr);
        @(posedge clk);
        #INPUT_DELAY;
        instr_rvalid = 1'b0;
      end
    end
  end

  initial begin : data_responder
    int wait_cycles;
    int idx;
    forever begin
      @(posedge clk);
      #INPUT_DELAY;
      if (data_req) begin
        wait_cycles = int'(rand_below(4));
        repeat (wait_cycles) begin
          @(posedge clk);
          #INPUT_DELAY;
        end
        idx = data_index(data_addr);
        if (idx < 0) begin
          $display("Error at %0d ns: data access to %h is outside the data region",
                   $time, data_addr);
          errors++;
          data_rdata = '0;
        end else begin
          if (data_we) begin
            data_mem[idx] = data_wdata;
          end
          data_rdata = data_mem[idx];
        end
        data_rvalid = 1'b1;
        @(posedge clk);
        #INPUT_DELAY;
        data_rvalid = 1'b0;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0d ns, the core stopped retiring instructions", $time);
    $display("Something failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    retire_t expected;
    int      retired;
    int      loads;
    int      stores;
    int      traps;
    int      test_errors;

    seed         = 32'hb045c7d8;
    errors       = 0;
    checks       = 0;
    clk          = 1'b0;
    arst_n       = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata  = '0;
    data_rvalid  = 1'b0;
    data_rdata   = '0;
    build_program();
    model_reset();
    for (int i = 0; i < DATA_WORDS; i++) begin
      data_mem[i] = data_fill(DATA_BASE + 32'(4 * i));
    end

    // Reset state and first fetch
    test_errors = errors;
    repeat (3) @(posedge clk);
    check_value("instr_req in reset", 64'(instr_req), 64'h0);
    check_value("data_req in reset", 64'(data_req), 64'h0);
    check_value("retire_valid in reset", 64'(retire_valid), 64'h0);
    check_value("retire_order in reset", retire_order, 64'h0);
    #INPUT_DELAY;
    arst_n = 1'b1;
    do begin
      @(negedge clk);
    end while (!instr_req);
    check_value("first fetch address", 64'(instr_addr), 64'h0);
    $display("Test reset_and_first_fetch done: %0d errors", errors - test_errors);

    // Random program against the model
    test_errors = errors;
    retired     = 0;
    loads       = 0;
    stores      = 0;
    traps       = 0;
    while (retired < NUM_INSNS) begin
      @(negedge clk);
      if (retire_valid) begin
        check_value("retire_order", retire_order, model_order);
        expected = model_step();
        compare_retire(expected);
        loads  += (expected.mem_rmask != 4'h0) ? 1 : 0;
        stores += (expected.mem_wmask != 4'h0) ? 1 : 0;
        traps  += expected.trap ? 1 : 0;
        retired++;
      end
    end
    $display("Test random_program done: %0d retired, %0d loads, %0d stores, %0d traps, %0d errors",
             retired, loads, stores, traps, errors - test_errors);

    $display("Tests run: 2, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+.
core_pkg.sv
core_alu.sv
core_decoder.sv
core_regfile.sv
core_pc_unit.sv
core_lsu.sv
core_retire.sv
core_ctrl_fsm.sv
core_top.sv
tb_core.sv

// ==== Makefile ====
# Verilator simulation of the core testbench

VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
